// File: run.sh
#!/usr/bin/env bash
# Build the arbiter testbench with Verilator, run it and search the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 --top-module uma_tb \
    -f uma.f -o uma_sim > build.log 2>&1 \
    && ./obj_dir/uma_sim > sim.log 2>&1 \
    && grep -qx "all tests passed" sim.log \
    && echo "simulation passed" \
    || { cat build.log sim.log 2>/dev/null; echo "simulation failed"; exit 1; }

// File: uma.f
+incdir+verilog
+incdir+verif
verilog/uma_pkg.sv
verilog/uma_slot_timer.sv
verilog/uma_channel.sv
verilog/uma_issue.sv
verilog/uma_top.sv
verif/uma_tb.sv

// File: verif/uma_tests.svh
// Directed memory arbiter tests, compiled inside the testbench module

function automatic client_bus_t idle_bus();
    client_bus_t bus;
    bus        = '0;
    bus.oe_n   = 1'b1;
    bus.we_n   = 1'b1;
    bus.rfsh_n = 1'b1;
    return bus;
endfunction

// Strobes given as {oe_n, we_n, rfsh_n}
task automatic set_request(input logic ch, input logic [2:0] strobe_n, input addr_t addr,
                           input data_t din, input logic [`UMA_SIZE_W-1:0] size);
    client[ch].addr     = addr;
    client[ch].din      = din;
    client[ch].din_size = size;
    client[ch].oe_n     = strobe_n[2];
    client[ch].we_n     = strobe_n[1];
    client[ch].rfsh_n   = strobe_n[0];
endtask

// Ack goes low one clock after the edge, then the client lets go of its strobes
task automatic launch_edges(input logic [1:0] chans);
    @(negedge CLK);
    if (chans[0]) begin
        check_value("ack_n[0]", 32'(ack_n[0]), 32'd0);
        client[0] = idle_bus();
    end
    if (chans[1]) begin
        check_value("ack_n[1]", 32'(ack_n[1]), 32'd0);
        client[1] = idle_bus();
    end
endtask

task automatic wait_acks_high(input logic [1:0] chans);
    int waited;
    waited = 0;
    while ((ack_n & chans) != chans && waited < WAIT_LIMIT) begin
        @(negedge CLK);
        waited++;
    end
    if ((ack_n & chans) != chans) begin
        report_failure($sformatf("ack_n stayed low for %0d cycles", WAIT_LIMIT));
    end
endtask

function automatic addr_t wrap_addr(input addr_t addr, input addr_t offset);
    logic [24:0] sum;
    sum = {1'b0, addr} + {1'b0, offset};
    return sum[23:0];       // Modulo 2^24
endfunction

task automatic check_log(input int idx, input logic [2:0] strobe_n, input addr_t addr);
    check_value("primary strobes", 32'(log_strobe_n[idx[5:0]]), 32'(strobe_n));
    check_value("primary addr", 32'(log_addr[idx[5:0]]), 32'(addr));
endtask

task automatic test_reset_state();
    check_value("primary strobes", 32'({prim.oe_n, prim.we_n, prim.rfsh_n}), 32'h7);
    check_value("ack_n", 32'(ack_n), 32'h3);
    check_value("dout[0]", 32'(dout[0]), 32'd0);
    check_value("dout[1]", 32'(dout[1]), 32'd0);
endtask

task automatic test_ch0_read();
    addr_t addr;
    addr_t target;
    int    first;
    addr           = addr_t'(random_bits(24));
    addr_offset[0] = '0;
    target         = wrap_addr(addr, addr_offset[0]);
    first          = log_count;
    set_request(1'b0, 3'b011, addr, '0, '0);
    launch_edges(2'b01);
    wait_acks_high(2'b01);
    check_value("primary access count", log_count, first + 1);
    check_log(first, 3'b011, target);
    check_value("dout[0]", 32'(dout[0]), 32'(mem[target[7:0]]));
endtask

// Client address and offset together always pass 2^24
task automatic test_ch1_write_read();
    addr_t                  addr;
    addr_t                  target;
    data_t                  wdata;
    logic [`UMA_SIZE_W-1:0] wsize;
    int                     first;
    addr           = 24'h100000 | addr_t'(random_bits(20));
    addr_offset[1] = 24'hf00000 | addr_t'(random_bits(12));
    wdata          = data_t'(random_bits(16));
    wsize          = `UMA_SIZE_W'(random_bits(`UMA_SIZE_W));
    target         = wrap_addr(addr, addr_offset[1]);
    first          = log_count;
    set_request(1'b1, 3'b101, addr, wdata, wsize);
    launch_edges(2'b10);
    wait_acks_high(2'b10);
    check_log(first, 3'b101, target);
    check_value("primary din", 32'(log_din[first[5:0]]), 32'(wdata));
    check_value("primary din_size", 32'(log_size[first[5:0]]), 32'(wsize));
    set_request(1'b1, 3'b011, addr, '0, '0);
    launch_edges(2'b10);
    wait_acks_high(2'b10);
    check_value("primary access count", log_count, first + 2);
    check_log(first + 1, 3'b011, target);
    check_value("dout[1]", 32'(dout[1]), 32'(wdata));
endtask

task automatic test_refresh();
    int first;
    first = log_count;
    set_request(1'b0, 3'b110, addr_t'(random_bits(24)), '0, '0);
    launch_edges(2'b01);
    wait_acks_high(2'b01);
    check_value("primary access count", log_count, first + 1);
    check_log(first, 3'b110, '0);
endtask

// Slot order decides which channel reaches the primary port first
task automatic test_concurrent_reads();
    addr_t      a0;
    addr_t      a1;
    addr_t      t0;
    addr_t      t1;
    logic [5:0] i0;
    logic [5:0] i1;
    logic       pair_ok;
    a0             = addr_t'(random_bits(24));
    a1             = addr_t'(random_bits(24));
    addr_offset[0] = addr_t'(random_bits(24));
    addr_offset[1] = addr_t'(random_bits(24));
    t0             = wrap_addr(a0, addr_offset[0]);
    t1             = wrap_addr(a1, addr_offset[1]);
    i0             = log_count[5:0];
    i1             = i0 + 6'd1;
    set_request(1'b0, 3'b011, a0, '0, '0);
    set_request(1'b1, 3'b011, a1, '0, '0);
    launch_edges(2'b11);
    wait_acks_high(2'b11);
    check_value("primary access count", 32'(log_count[5:0]), 32'(i0 + 6'd2));
    check_value("strobes of first access", 32'(log_strobe_n[i0]), 32'h3);
    check_value("strobes of second access", 32'(log_strobe_n[i1]), 32'h3);
    pair_ok = (log_addr[i0] == t0 && log_addr[i1] == t1) ||
              (log_addr[i0] == t1 && log_addr[i1] == t0);
    check_value("primary addr pair match", 32'(pair_ok), 32'd1);
    check_value("dout[0]", 32'(dout[0]), 32'(mem[t0[7:0]]));
    check_value("dout[1]", 32'(dout[1]), 32'(mem[t1[7:0]]));
endtask

// File: verif/uma_tb.sv
// Memory arbiter testbench with clock, reset, primary RAM model and directed test sequence
`timescale 1ns/1ps
`include "uma_settings.svh"

module uma_tb;
    import uma_pkg::*;

    localparam int WAIT_LIMIT     = 4 * `UMA_SLOT_DIV;  // Longest wait for one access
    localparam int TIMEOUT_CYCLES = 2000;               // Five tests of four host periods, wide margin

    logic              CLK = 1'b0;
    logic              RESET_n;
    logic              host_clk_en;
    client_bus_t [1:0] client;
    addr_t [1:0]       addr_offset;
    data_t [1:0]       dout;
    logic [1:0]        ack_n;
    prim_cmd_t         prim;
    data_t             prim_dout;
    logic              prim_ack_n;

    data_t                  mem [0:255];
    addr_t                  log_addr [0:63];
    data_t                  log_din [0:63];
    logic [`UMA_SIZE_W-1:0] log_size [0:63];
    logic [2:0]             log_strobe_n [0:63];  // {oe_n, we_n, rfsh_n} per primary access
    int                     log_count;
    logic [31:0]            lfsr_state;
    int                     errors;
    int                     checks;
    int                     cycle_count = 0;

    uma_top dut (
        .CLK         (CLK),
        .RESET_n     (RESET_n),
        .host_clk_en (host_clk_en),
        .client      (client),
        .addr_offset (addr_offset),
        .dout        (dout),
        .ack_n       (ack_n),
        .prim        (prim),
        .prim_dout   (prim_dout),
        .prim_ack_n  (prim_ack_n)
    );

    always #4 CLK = ~CLK;

    // One host enable per host period
    initial begin : host_enable
        int phase;
        host_clk_en = 1'b0;
        phase       = 0;
        forever begin
            @(negedge CLK);
            host_clk_en = RESET_n && (phase == 0);
            phase       = (phase + 1) % `UMA_SLOT_DIV;
        end
    end

    // Primary RAM answers on the falling edge after a strobe and holds read data until the next read
    initial begin : prim_ram
        int i;
        for (i = 0; i < 256; i++) begin
            mem[i[7:0]] = {i[7:0], ~i[7:0]} ^ 16'hc35a;
        end
        prim_ack_n = 1'b1;
        prim_dout  = '0;
        log_count  = 0;
        forever begin
            @(negedge CLK);
            if (!prim_ack_n) begin
                prim_ack_n = 1'b1;  // Single clock acknowledge
            end else if (RESET_n && !(prim.oe_n && prim.we_n && prim.rfsh_n)) begin
                log_addr[log_count[5:0]]     = prim.addr;
                log_din[log_count[5:0]]      = prim.din;
                log_size[log_count[5:0]]     = prim.din_size;
                log_strobe_n[log_count[5:0]] = {prim.oe_n, prim.we_n, prim.rfsh_n};
                log_count++;
                if (!prim.oe_n) prim_dout = mem[prim.addr[7:0]];
                if (!prim.we_n) mem[prim.addr[7:0]] = prim.din;
                prim_ack_n = 1'b0;
            end
        end
    end

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run stopped after %0d cycles before the tests finished", TIMEOUT_CYCLES);
            $display("tests failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("%0t ns: %s", $time, what);
    endtask

    // Galois LFSR for x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_step_bit();
        logic out;
        out        = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) lfsr_state = lfsr_state ^ 32'h8020_0003;
        return out;
    endfunction

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        int          i;
        value = '0;
        for (i = 0; i < count; i++) begin
            value = {value[30:0], lfsr_step_bit()};
        end
        return value;
    endfunction

    `include "uma_tests.svh"

    initial begin
        errors      = 0;
        checks      = 0;
        lfsr_state  = 32'd86836;
        RESET_n     = 1'b0;
        client[0]   = idle_bus();
        client[1]   = idle_bus();
        addr_offset = '0;
        repeat (3) @(negedge CLK);
        RESET_n = 1'b1;
        test_reset_state();
        test_ch0_read();
        test_ch1_write_read();
        test_refresh();
        test_concurrent_reads();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: verilog/uma_channel.sv
// Arbiter channel that catches client strobe edges, holds the request and returns read data
`timescale 1ns/1ps
`include "uma_settings.svh"

module uma_channel #(
    parameter int EXEC_DELAY = 1
) (
    input  logic                 CLK,
    input  logic                 RESET_n,
    input  uma_pkg::client_bus_t client,
    input  logic                 slot,
    input  logic                 slot_any,
    output uma_pkg::data_t       dout,
    output logic                 ack_n,
    output logic                 launch,
    output uma_pkg::mem_req_t    req,
    input  uma_pkg::data_t       prim_dout
);
    import uma_pkg::*;

    // Bit positions in the strobe vectors
    localparam int OE   = 2;
    localparam int WE   = 1;
    localparam int RFSH = 0;

    logic [EXEC_DELAY-1:0]  slot_dly;
    logic [2:0]             strobe_n;
    logic [2:0]             prev_n;
    logic [2:0]             det;
    logic [2:0]             held;      // Edges seen but not yet launched
    logic [2:0]             pend;
    logic                   busy;
    logic                   done;
    logic                   det_addr;
    addr_t                  save_addr;
    data_t                  save_din;
    logic [`UMA_SIZE_W-1:0] save_size;
    addr_t                  cur_addr;
    data_t                  cur_din;
    logic [`UMA_SIZE_W-1:0] cur_size;

    assign strobe_n = {client.oe_n, client.we_n, client.rfsh_n};

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            prev_n <= '1;
        end else begin
            prev_n <= strobe_n;
        end
    end

    assign det      = prev_n & ~strobe_n;  // High to low only
    assign pend     = det | held;
    assign det_addr = det[OE] | det[WE];

    // Own slot pulse pushed down the execution delay line
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            slot_dly <= '0;
        end else begin
            slot_dly <= (slot_dly << 1) | EXEC_DELAY'(slot);
        end
    end

    assign launch = slot_dly[EXEC_DELAY-1] && (|pend);
    assign done   = slot_any && busy;

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            held <= '0;
        end else if (launch) begin
            held <= '0;             // Everything pending goes out together
        end else begin
            held <= held | det;
        end
    end

    always_ff @(posedge CLK) begin
        if (det_addr) begin
            save_addr <= client.addr;
        end
        if (det[WE]) begin
            save_din  <= client.din;
            save_size <= client.din_size;
        end
    end

    // Bypass so an edge in the launch cycle is served at once
    assign cur_addr = det_addr ? client.addr     : save_addr;
    assign cur_din  = det[WE]  ? client.din      : save_din;
    assign cur_size = det[WE]  ? client.din_size : save_size;

    always_comb begin
        req.oe   = pend[OE];
        req.we   = pend[WE];
        req.rfsh = pend[RFSH];
        if (pend[OE] || pend[WE]) begin
            req.addr     = cur_addr;
            req.din      = cur_din;
            req.din_size = cur_size;
        end else begin
            req.addr     = '0;          // Refresh carries no address or data
            req.din      = '0;
            req.din_size = '0;
        end
    end

    // Busy from launch until the next slot of either channel
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            busy <= 1'b0;
        end else if (launch) begin
            busy <= 1'b1;
        end else if (done) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            dout  <= '0;
            ack_n <= 1'b1;
        end else begin
            if (done) begin
                dout <= prim_dout;
            end
            if (|det) begin
                ack_n <= 1'b0;
            end else if (done && !(|pend)) begin
                ack_n <= 1'b1;      // Stays low while a newer request waits
            end
        end
    end

    // A launch only serves a request the client is still waiting on
    a_launch_pending: assert property (@(posedge CLK) disable iff (!RESET_n)
        launch |-> (|det) || (!ack_n && (|held)))
        else $error("uma_channel: launch without a pending request");

endmodule

// File: verilog/uma_issue.sv
// Issue stage that drives the primary RAM command from the launching channel
`timescale 1ns/1ps

module uma_issue (
    input  logic                   CLK,
    input  logic                   RESET_n,
    input  logic [1:0]             launch,
    input  uma_pkg::mem_req_t [1:0] req,
    input  uma_pkg::addr_t [1:0]   addr_offset,
    input  logic                   prim_ack_n,
    output uma_pkg::prim_cmd_t     prim
);
    import uma_pkg::*;

    logic     sel;         // Index of the launching channel
    mem_req_t pick;
    logic     rw;
    addr_t    pick_addr;

    assign sel  = !launch[0];   // Channel 0 first
    assign pick = req[sel];
    assign rw   = pick.oe || pick.we;

    // Offset wraps at 24 bits
    assign pick_addr = rw ? addr_t'(pick.addr + addr_offset[sel]) : '0;

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            prim.addr     <= '0;
            prim.din      <= '0;
            prim.din_size <= '0;
            prim.oe_n     <= 1'b1;
            prim.we_n     <= 1'b1;
            prim.rfsh_n   <= 1'b1;
        end else if (!prim_ack_n) begin
            // Primary RAM has taken the access
            prim.oe_n   <= 1'b1;
            prim.we_n   <= 1'b1;
            prim.rfsh_n <= 1'b1;
        end else if (|launch) begin
            prim.addr     <= pick_addr;
            prim.din      <= rw ? pick.din : '0;
            prim.din_size <= rw ? pick.din_size : '0;
            prim.oe_n     <= !pick.oe;
            prim.we_n     <= !pick.we;
            prim.rfsh_n   <= !pick.rfsh;
        end
    end

    // Slot alternation and the delay lines keep the channels apart
    a_launch_exclusive: assert property (@(posedge CLK) disable iff (!RESET_n)
        !(launch[0] && launch[1]))
        else $error("uma_issue: both channels launched in one clock");

endmodule

// File: verilog/uma_pkg.sv
// Memory arbiter types for client buses, launched requests and primary port commands
`include "uma_settings.svh"

package uma_pkg;

    typedef logic [`UMA_ADDR_W-1:0] addr_t;
    typedef logic [`UMA_DATA_W-1:0] data_t;

    // Levels driven by one client, strobes active low
    typedef struct packed {
        addr_t                  addr;
        data_t                  din;
        logic [`UMA_SIZE_W-1:0] din_size;
        logic                   oe_n;
        logic                   we_n;
        logic                   rfsh_n;
    } client_bus_t;

    // One request handed from a channel to the issue stage
    typedef struct packed {
        logic                   oe;
        logic                   we;
        logic                   rfsh;
        addr_t                  addr;
        data_t                  din;
        logic [`UMA_SIZE_W-1:0] din_size;
    } mem_req_t;

    typedef struct packed {
        addr_t                  addr;
        data_t                  din;
        logic [`UMA_SIZE_W-1:0] din_size;
        logic                   oe_n;
        logic                   we_n;
        logic                   rfsh_n;
    } prim_cmd_t;

endpackage

// File: verilog/uma_settings.svh
// Memory arbiter settings for slot timing, bus widths and per-channel execution delays
`ifndef UMA_SETTINGS_SVH
`define UMA_SETTINGS_SVH

// Clocks per host period
`define UMA_SLOT_DIV 30

// Clocks from the host enable to the first slot
`define UMA_SLOT_DELAY 5

// Client and primary bus widths
`define UMA_ADDR_W 24
`define UMA_DATA_W 16
`define UMA_SIZE_W 2

// Slot to launch latency, main RAM then video RAM
`define UMA_MRAM_DELAY 1
`define UMA_VRAM_DELAY 2

// Number of client channels sharing the primary port
`define UMA_CHANNELS 2

`endif

// File: verilog/uma_slot_timer.sv
// Slot timer locked to the host clock enable, three access slots per host period
`timescale 1ns/1ps
`include "uma_settings.svh"

module uma_slot_timer (
    input  logic       CLK,
    input  logic       RESET_n,
    input  logic       host_clk_en,
    output logic [1:0] slot,
    output logic       slot_any
);
    localparam int CNT_W = $clog2(`UMA_SLOT_DIV);

    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`UMA_SLOT_DIV - 1);

    // Slots sit a third of a host period apart
    localparam logic [CNT_W-1:0] SLOT_A = CNT_W'(`UMA_SLOT_DELAY);
    localparam logic [CNT_W-1:0] SLOT_B = CNT_W'(`UMA_SLOT_DELAY + `UMA_SLOT_DIV / 3);
    localparam logic [CNT_W-1:0] SLOT_C = CNT_W'(`UMA_SLOT_DELAY + `UMA_SLOT_DIV * 2 / 3);

    logic [CNT_W-1:0] cnt;
    logic             toggle;   // Channel that receives the next pulse
    logic             hit;

    // Restart on every host enable, park at the last count
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            cnt <= '0;
        end else if (host_clk_en) begin
            cnt <= '0;
        end else if (cnt != CNT_LAST) begin
            cnt <= cnt + 1'b1;
        end
    end

    assign hit = (cnt == SLOT_A) || (cnt == SLOT_B) || (cnt == SLOT_C);

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            slot     <= 2'b00;
            slot_any <= 1'b0;
            toggle   <= 1'b0;
        end else begin
            slot_any <= hit;
            slot     <= hit ? (toggle ? 2'b10 : 2'b01) : 2'b00;
            if (hit) begin
                toggle <= ~toggle;  // Alternation carries across host periods
            end
        end
    end

endmodule

// File: verilog/uma_top.sv
// Memory arbiter top sharing one primary RAM port between main and video RAM clients
`timescale 1ns/1ps
`include "uma_settings.svh"

module uma_top (
    input  logic                                  CLK,
    input  logic                                  RESET_n,
    input  logic                                  host_clk_en,
    input  uma_pkg::client_bus_t [`UMA_CHANNELS-1:0] client,
    input  uma_pkg::addr_t [`UMA_CHANNELS-1:0]       addr_offset,
    output uma_pkg::data_t [`UMA_CHANNELS-1:0]       dout,
    output logic [`UMA_CHANNELS-1:0]                 ack_n,
    output uma_pkg::prim_cmd_t                       prim,
    input  uma_pkg::data_t                           prim_dout,
    input  logic                                     prim_ack_n
);
    import uma_pkg::*;

    logic [1:0]                     slot;
    logic                           slot_any;
    logic [`UMA_CHANNELS-1:0]       launch;
    mem_req_t [`UMA_CHANNELS-1:0]   req;

    uma_slot_timer u_timer (
        .CLK         (CLK),
        .RESET_n     (RESET_n),
        .host_clk_en (host_clk_en),
        .slot        (slot),
        .slot_any    (slot_any)
    );

    // Main RAM
    uma_channel #(.EXEC_DELAY(`UMA_MRAM_DELAY)) u_mram (
        .CLK       (CLK),
        .RESET_n   (RESET_n),
        .client    (client[0]),
        .slot      (slot[0]),
        .slot_any  (slot_any),
        .dout      (dout[0]),
        .ack_n     (ack_n[0]),
        .launch    (launch[0]),
        .req       (req[0]),
        .prim_dout (prim_dout)
    );

    // Video RAM
    uma_channel #(.EXEC_DELAY(`UMA_VRAM_DELAY)) u_vram (
        .CLK       (CLK),
        .RESET_n   (RESET_n),
        .client    (client[1]),
        .slot      (slot[1]),
        .slot_any  (slot_any),
        .dout      (dout[1]),
        .ack_n     (ack_n[1]),
        .launch    (launch[1]),
        .req       (req[1]),
        .prim_dout (prim_dout)
    );

    uma_issue u_issue (
        .CLK         (CLK),
        .RESET_n     (RESET_n),
        .launch      (launch),
        .req         (req),
        .addr_offset (addr_offset),
        .prim_ack_n  (prim_ack_n),
        .prim        (prim)
    );

endmodule
